/* common/ffe_pkg.sv */
`default_nettype none

package ffe_pkg;

   localparam int ffe_width   = 4;
   localparam int ffe_length  = 6;
   localparam int code_bits   = 8;
   localparam int weight_bits = 10;
   localparam int result_bits = 10;
   localparam int shift_bits  = 4;
   // growth of the sum over ffe_length products.
   localparam int acc_bits    = code_bits + weight_bits + $clog2(ffe_length);

   typedef logic signed [code_bits-1:0]   code_t;
   typedef logic signed [weight_bits-1:0] weight_t;
   typedef logic signed [result_bits-1:0] result_t;
   typedef logic [shift_bits-1:0]         shift_t;
   typedef logic signed [acc_bits-1:0]    acc_t;
   typedef logic [15:0]                   wb_data_t;
   typedef logic [7:0]                    wb_addr_t;

   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* ffe/flat_ffe.sv */
`timescale 1ns/1ps
`default_nettype none

module flat_ffe #(
   parameter int length      = ffe_pkg::ffe_length,
   parameter int width       = ffe_pkg::ffe_width,
   parameter int code_bits   = ffe_pkg::code_bits,
   parameter int weight_bits = ffe_pkg::weight_bits
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  ffe_pkg::code_t   [width-1:0]  codes,
   input  logic                          code_valid,
   input  ffe_pkg::weight_t [length-1:0] weights,
   output ffe_pkg::acc_t    [width-1:0]  sums,
   output logic                          sums_valid
);
   import ffe_pkg::*;

   localparam int prod_bits = code_bits + weight_bits;
   localparam int win_len   = width + length - 1;

   // history holds the newest length-1 codes of the last valid word.
   // index 0 is the oldest sample.
   code_t [length-2:0]  hist;

   // serial window, oldest first: history, then lanes 0..width-1.
   code_t [win_len-1:0] window;
   acc_t  [width-1:0]   sums_c;

   assign window = {codes, hist};

   // lane j sits at window[length-1+j]; tap k reaches k samples back.
   always_comb begin : mac
      logic signed [prod_bits-1:0] prod;
      for (int j = 0; j < width; j++) begin
         sums_c[j] = '0;
         for (int k = 0; k < length; k++) begin
            prod = $signed(window[length - 1 + j - k]) * $signed(weights[k]);
            sums_c[j] = sums_c[j] + acc_t'(prod);
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hist       <= '0;
         sums_valid <= 1'b0;
      end else begin
         sums_valid <= code_valid;
         // gaps in the stream leave the history untouched.
         if (code_valid) begin
            hist <= window[win_len-1 -: length-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (code_valid) begin
         sums <= sums_c;
      end
   end

endmodule

`default_nettype wire

/* ffe/ffe_result_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_result_scaler #(
   parameter int width       = ffe_pkg::ffe_width,
   parameter int result_bits = ffe_pkg::result_bits,
   parameter int shift_bits  = ffe_pkg::shift_bits
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  ffe_pkg::acc_t    [width-1:0] sums,
   input  logic                         sums_valid,
   input  ffe_pkg::shift_t  [width-1:0] shifts,
   output ffe_pkg::result_t [width-1:0] results,
   output logic                         result_valid
);
   import ffe_pkg::*;

   localparam acc_t res_max = acc_t'(2 ** (result_bits - 1) - 1);
   localparam acc_t res_min = acc_t'(-(2 ** (result_bits - 1)));

   // the shifts that were in force when the current word was accepted.
   shift_t  [width-1:0] shifts_q;
   result_t [width-1:0] clamped;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         shifts_q <= '0;
      end else begin
         shifts_q <= shifts;
      end
   end

   always_comb begin : scale
      acc_t                  sum;
      acc_t                  shifted;
      logic [shift_bits-1:0] sh;
      for (int j = 0; j < width; j++) begin
         sum     = sums[j];
         sh      = shifts_q[j];
         shifted = sum >>> sh;
         if (shifted > res_max) begin
            clamped[j] = result_t'(res_max);
         end else if (shifted < res_min) begin
            clamped[j] = result_t'(res_min);
         end else begin
            clamped[j] = result_t'(shifted);
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= sums_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (sums_valid) begin
         results <= clamped;
      end
   end

endmodule

`default_nettype wire

/* verilog/ffe_coef_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_coef_regs #(
   parameter int length      = ffe_pkg::ffe_length,
   parameter int width       = ffe_pkg::ffe_width,
   parameter int weight_bits = ffe_pkg::weight_bits,
   parameter int shift_bits  = ffe_pkg::shift_bits
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  ffe_pkg::wb_req_t              wb_req,
   output ffe_pkg::wb_rsp_t              wb_rsp,
   output ffe_pkg::weight_t [length-1:0] weights,
   output ffe_pkg::shift_t  [width-1:0]  shifts
);
   import ffe_pkg::*;

   localparam int data_bits = $bits(wb_data_t);

   logic     req_active;
   logic     access;
   logic     wr_en;
   logic     ack_q;
   wb_data_t rd_data;
   wb_data_t rd_q;

   assign req_active = wb_req.cyc & wb_req.stb;
   // a new access is a request seen while ack is low.
   assign access     = req_active & ~ack_q;
   assign wr_en      = access & wb_req.we;

   // weights read back sign-extended, shifts zero-extended.
   always_comb begin
      rd_data = '0;
      for (int k = 0; k < length; k++) begin
         if (wb_req.adr == wb_addr_t'(k)) begin
            rd_data = {{(data_bits - weight_bits){weights[k][weight_bits-1]}}, weights[k]};
         end
      end
      for (int i = 0; i < width; i++) begin
         if (wb_req.adr == wb_addr_t'(length + i)) begin
            rd_data = {{(data_bits - shift_bits){1'b0}}, shifts[i]};
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // the write lands on the same edge that raises ack.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         weights <= '0;
         shifts  <= '0;
      end else if (wr_en) begin
         for (int k = 0; k < length; k++) begin
            if (wb_req.adr == wb_addr_t'(k)) begin
               weights[k] <= wb_req.dat[weight_bits-1:0];
            end
         end
         for (int i = 0; i < width; i++) begin
            if (wb_req.adr == wb_addr_t'(length + i)) begin
               shifts[i] <= wb_req.dat[shift_bits-1:0];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rd_q <= rd_data;
      end
   end

   assign wb_rsp.ack = ack_q;
   assign wb_rsp.dat = rd_q;

endmodule

`default_nettype wire

/* verilog/ffe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_top #(
   parameter int width       = ffe_pkg::ffe_width,
   parameter int length      = ffe_pkg::ffe_length,
   parameter int code_bits   = ffe_pkg::code_bits,
   parameter int weight_bits = ffe_pkg::weight_bits,
   parameter int result_bits = ffe_pkg::result_bits,
   parameter int shift_bits  = ffe_pkg::shift_bits
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  ffe_pkg::wb_req_t             wb_req,
   output ffe_pkg::wb_rsp_t             wb_rsp,
   input  ffe_pkg::code_t   [width-1:0] codes,
   input  logic                         code_valid,
   output ffe_pkg::result_t [width-1:0] results,
   output logic                         result_valid
);
   import ffe_pkg::*;

   weight_t [length-1:0] weights;
   shift_t  [width-1:0]  shifts;
   acc_t    [width-1:0]  sums;
   logic                 sums_valid;

   ffe_coef_regs #(
      .length      (length),
      .width       (width),
      .weight_bits (weight_bits),
      .shift_bits  (shift_bits)
   ) coef_regs_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .weights (weights),
      .shifts  (shifts)
   );

   flat_ffe #(
      .length      (length),
      .width       (width),
      .code_bits   (code_bits),
      .weight_bits (weight_bits)
   ) flat_ffe_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .codes      (codes),
      .code_valid (code_valid),
      .weights    (weights),
      .sums       (sums),
      .sums_valid (sums_valid)
   );

   ffe_result_scaler #(
      .width       (width),
      .result_bits (result_bits),
      .shift_bits  (shift_bits)
   ) result_scaler_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .sums         (sums),
      .sums_valid   (sums_valid),
      .shifts       (shifts),
      .results      (results),
      .result_valid (result_valid)
   );

endmodule

`default_nettype wire

/* verification/ffe_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_properties (
   input logic             clk,
   input logic             arst_n,
   input ffe_pkg::wb_req_t wb_req,
   input ffe_pkg::wb_rsp_t wb_rsp,
   input logic             code_valid,
   input logic             result_valid
);

   ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
      else $error("ack raised outside an active bus cycle");

   // one ack per access.
   ack_single: assert property (@(posedge clk) disable iff (!arst_n)
      wb_rsp.ack |=> !wb_rsp.ack)
      else $error("ack held high for two cycles");

   valid_delay: assert property (@(posedge clk) disable iff (!arst_n)
      result_valid == $past(code_valid, 2))
      else $error("result_valid does not follow code_valid by two cycles");

endmodule

bind ffe_top ffe_properties props_inst (
   .clk          (clk),
   .arst_n       (arst_n),
   .wb_req       (wb_req),
   .wb_rsp       (wb_rsp),
   .code_valid   (code_valid),
   .result_valid (result_valid)
);

`default_nettype wire

/* verification/ffe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ffe_tb;
   import ffe_pkg::*;

   localparam int width    = ffe_width;
   localparam int length   = ffe_length;
   localparam int regs     = ffe_length + ffe_width;
   localparam int timeout  = 32;
   localparam int res_max  = 2 ** (result_bits - 1) - 1;
   localparam int res_min  = -(2 ** (result_bits - 1));
   localparam int code_max = 2 ** (code_bits - 1) - 1;

   logic                clk;
   logic                arst_n;
   wb_req_t             wb_req;
   wb_rsp_t             wb_rsp;
   code_t   [width-1:0] codes;
   logic                code_valid;
   result_t [width-1:0] results;
   logic                result_valid;

   logic [31:0] lfsr_state;
   int          model_weights[length];
   int          model_shifts[width];
   int          serial_hist[$];
   int          expected[$];
   int          clamp_high;
   int          clamp_low;
   wb_data_t    reg_image[regs];
   wb_data_t    rdata;
   wb_data_t    new_w0;
   wb_data_t    new_wl;

   ffe_top ffe_top_inst (.*);

   always #10 clk = ~clk;

   task automatic report_failure();
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // galois step for taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // weights read back sign-extended and shifts zero-extended; other addresses read zero.
   function automatic wb_data_t readback_value(input int adr, input wb_data_t dat);
      if (adr < length) begin
         return {{(16 - weight_bits){dat[weight_bits-1]}}, dat[weight_bits-1:0]};
      end else if (adr < regs) begin
         return {{(16 - shift_bits){1'b0}}, dat[shift_bits-1:0]};
      end
      return '0;
   endfunction

   task automatic wb_access(input logic we, input int adr, input wb_data_t dat);
      bit got_ack;
      got_ack = 1'b0;
      @(posedge clk);
      wb_req.cyc <= 1'b1;
      wb_req.stb <= 1'b1;
      wb_req.we  <= we;
      wb_req.adr <= wb_addr_t'(adr);
      wb_req.dat <= dat;
      for (int i = 0; i < timeout && !got_ack; i++) begin
         @(posedge clk);
         got_ack = wb_rsp.ack;
      end
      rdata = wb_rsp.dat;
      assert (got_ack) else begin
         $display("no Wishbone ack within %0d cycles for address %0d", timeout, adr);
         report_failure();
      end
      wb_req <= '0;
   endtask

   task automatic write_reg(input int adr, input wb_data_t dat);
      wb_access(1'b1, adr, dat);
      if (adr < regs) begin
         reg_image[adr] = readback_value(adr, dat);
      end
   endtask

   task automatic read_check(input int adr, input wb_data_t exp);
      wb_access(1'b0, adr, '0);
      assert (rdata === exp) else begin
         $display("[ERROR] %0t wb_rsp.dat got %h expected %h at address %0d",
                  $time, rdata, exp, adr);
         report_failure();
      end
   endtask

   task automatic check_regs();
      for (int a = 0; a < regs; a++) begin
         read_check(a, reg_image[a]);
      end
   endtask

   task automatic mirror_write(input wb_addr_t adr, input wb_data_t dat);
      if (int'(adr) < length) begin
         model_weights[adr] = int'(weight_t'(dat[weight_bits-1:0]));
      end else if (int'(adr) < regs) begin
         model_shifts[int'(adr) - length] = int'(dat[shift_bits-1:0]);
      end
   endtask

   // serial FIR over the valid samples with the newest at the back of the history.
   task automatic model_word(input code_t [width-1:0] word);
      longint sum;
      longint shifted;
      int     last;
      for (int j = 0; j < width; j++) begin
         serial_hist.push_back(int'(word[j]));
         void'(serial_hist.pop_front());
         last = serial_hist.size() - 1;
         sum  = 0;
         for (int k = 0; k < length; k++) begin
            sum += longint'(model_weights[k]) * serial_hist[last - k];
         end
         shifted = sum >>> model_shifts[j];
         if (shifted > res_max) begin
            expected.push_back(res_max);
            clamp_high++;
         end else if (shifted < res_min) begin
            expected.push_back(res_min);
            clamp_low++;
         end else begin
            expected.push_back(int'(shifted));
         end
      end
   endtask

   task automatic check_word();
      int exp;
      assert (expected.size() >= width) else begin
         $display("result_valid high at %0t with no word in flight", $time);
         report_failure();
      end
      for (int j = 0; j < width; j++) begin
         exp = expected.pop_front();
         assert (int'(results[j]) == exp) else begin
            $display("[ERROR] %0t results[%0d] got %0d expected %0d",
                     $time, j, results[j], exp);
            report_failure();
         end
      end
   endtask

   // writes take effect for words sampled after the ack edge.
   always @(posedge clk) begin
      if (arst_n) begin
         if (wb_rsp.ack && wb_req.we) begin
            mirror_write(wb_req.adr, wb_req.dat);
         end
         if (result_valid) begin
            check_word();
         end
         if (code_valid) begin
            model_word(codes);
         end
      end
   end

   task automatic drive_stream(input int cycles, input bit gaps, input bit full_scale);
      code_t [width-1:0] word;
      logic              valid;
      bit                drained;
      drained = 1'b0;
      for (int n = 0; n < cycles; n++) begin
         valid = gaps ? (take_bits(2) != 0) : 1'b1;
         for (int j = 0; j < width; j++) begin
            if (full_scale) begin
               word[j] = (take_bits(1) != 0) ? code_t'(code_max) : code_t'(-code_max - 1);
            end else begin
               word[j] = code_t'(take_bits(code_bits));
            end
         end
         @(posedge clk);
         code_valid <= valid;
         codes      <= word;
      end
      @(posedge clk);
      code_valid <= 1'b0;
      for (int i = 0; i < timeout && !drained; i++) begin
         @(negedge clk);
         drained = (expected.size() == 0);
      end
      assert (drained) else begin
         $display("results still missing %0d cycles after the stream ended", timeout);
         report_failure();
      end
   endtask

   initial begin
      clk        = 1'b0;
      arst_n     = 1'b0;
      wb_req     = '0;
      codes      = '0;
      code_valid = 1'b0;
      lfsr_state = 32'h256b;
      clamp_high = 0;
      clamp_low  = 0;
      foreach (reg_image[a]) begin
         reg_image[a] = '0;
      end
      repeat (length) serial_hist.push_back(0);
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      assert (!result_valid && !wb_rsp.ack) else begin
         $display("[ERROR] %0t result_valid/ack got %b/%b expected 0/0",
                  $time, result_valid, wb_rsp.ack);
         report_failure();
      end
      check_regs();

      for (int a = 0; a < regs; a++) begin
         write_reg(a, wb_data_t'(take_bits(16)));
      end
      check_regs();
      write_reg(regs, 16'hffff);
      write_reg(200, 16'h5a5a);
      read_check(regs, '0);
      read_check(200, '0);
      check_regs();

      // unit impulse on tap 0 passes codes straight through.
      write_reg(0, 16'h0001);
      for (int a = 1; a < regs; a++) begin
         write_reg(a, '0);
      end
      drive_stream(20, 1'b0, 1'b0);

      for (int k = 0; k < length; k++) begin
         write_reg(k, wb_data_t'(take_bits(16)));
      end
      for (int j = 0; j < width; j++) begin
         write_reg(length + j, wb_data_t'(4 + 2 * j));
      end
      drive_stream(60, 1'b1, 1'b0);

      for (int a = 0; a < regs; a++) begin
         write_reg(a, (a < length) ? 16'h01ff : 16'h0000);
      end
      clamp_high = 0;
      clamp_low  = 0;
      drive_stream(30, 1'b1, 1'b1);
      assert (clamp_high > 0 && clamp_low > 0) else begin
         $display("full-scale stream did not reach both output limits");
         report_failure();
      end

      for (int a = 0; a < regs; a++) begin
         write_reg(a, (a < length) ? wb_data_t'(take_bits(16)) : 16'h0006);
      end
      new_w0 = wb_data_t'(take_bits(16));
      new_wl = wb_data_t'(take_bits(16));
      fork
         drive_stream(40, 1'b0, 1'b0);
         begin
            repeat (10) @(posedge clk);
            write_reg(0, new_w0);
            write_reg(length - 1, new_wl);
            write_reg(length + 1, 16'h000f);
         end
      join
      check_regs();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
common/ffe_pkg.sv
ffe/flat_ffe.sv
ffe/ffe_result_scaler.sv
verilog/ffe_coef_regs.sv
verilog/ffe_top.sv
verification/ffe_properties.sv
verification/ffe_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ffe_tb -f list.f -o ffe_sim \
   > build.log 2>&1 \
   && ./obj_dir/ffe_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null | tail -n 40
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed, see build.log and sim.log"; exit 1; }
